// File: common/dsp_defines.svh
`ifndef DSP_DEFINES_SVH
`define DSP_DEFINES_SVH

// A and D operand width
`define DSP_AD_W 26

// pre-adder result, one guard bit over A/D
`define DSP_PRE_W 27

// coefficient width
`define DSP_COEF_W 18

// P, C and PCIN width
`define DSP_ACC_W 48

// cycles from a sample edge to its P register edge, counted inclusive
`define DSP_LATENCY 4

`endif

// File: common/dsp_pkg.sv
`default_nettype none
`include "dsp_defines.svh"

package dsp_pkg;

    // operand words, all two's complement
    typedef logic signed [`DSP_AD_W-1:0]   ad_t;
    typedef logic signed [`DSP_PRE_W-1:0]  pre_t;
    typedef logic signed [`DSP_COEF_W-1:0] coef_t;
    typedef logic signed [`DSP_ACC_W-1:0]  acc_t;

    // per-sample operation word
    typedef struct packed {
        // D-A instead of D+A
        logic sub_a;
        // add the C operand
        logic use_c;
        // subtract C, only meaningful with use_c
        logic sub_c;
        // add the cascade input
        logic add_pcin;
    } dsp_op_t;

    // fields needed at the pre-adder
    typedef struct packed {
        logic sub_a;
    } pre_ctrl_t;

    // fields needed at the post-adder
    typedef struct packed {
        logic use_c;
        logic sub_c;
        logic add_pcin;
    } post_ctrl_t;

endpackage

`default_nettype wire

// File: hw/dsp_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_ctrl (
    input  wire                    clk_i,
    input  wire                    arst_n_i,
    input  wire dsp_pkg::dsp_op_t  op_i,
    output dsp_pkg::pre_ctrl_t     pre_ctrl_o,
    output dsp_pkg::post_ctrl_t    post_ctrl_o
);

    import dsp_pkg::*;

    // op_q sits beside the A/D input registers
    dsp_op_t    op_q;
    post_ctrl_t post_fields;
    // beside the pre-add register, then beside the multiply register
    post_ctrl_t post_d1_q;
    post_ctrl_t post_d2_q;

    assign post_fields = '{
        use_c:    op_q.use_c,
        sub_c:    op_q.sub_c,
        add_pcin: op_q.add_pcin
    };

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_q      <= '0;
            post_d1_q <= '0;
            post_d2_q <= '0;
        end else begin
            op_q      <= op_i;
            post_d1_q <= post_fields;
            post_d2_q <= post_d1_q;
        end
    end

    assign pre_ctrl_o  = '{sub_a: op_q.sub_a};
    assign post_ctrl_o = post_d2_q;

    // a subtract request for C is meaningless unless C is selected
    a_sub_c_needs_use_c : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        op_q.sub_c |-> op_q.use_c
    ) else $error("dsp_ctrl: sub_c set without use_c");

endmodule

`default_nettype wire

// File: hw/coeff_bank.sv
`timescale 1ns/1ps
`default_nettype none

module coeff_bank (
    input  wire                  clk_i,
    input  wire                  arst_n_i,
    input  wire dsp_pkg::coef_t  b_i,
    input  wire                  load_i,
    input  wire                  update_i,
    output dsp_pkg::coef_t       coef_active_o,
    output dsp_pkg::coef_t       bcout_o
);

    import dsp_pkg::*;

    coef_t shadow_q;
    coef_t active_q;

    // load fills the shadow, update copies the pre-edge shadow into use
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            shadow_q <= '0;
            active_q <= '0;
        end else begin
            if (load_i) begin
                shadow_q <= b_i;
            end
            if (update_i) begin
                active_q <= shadow_q;
            end
        end
    end

    assign coef_active_o = active_q;
    // shadow value feeds the next slice in a chain
    assign bcout_o       = shadow_q;

    a_strobes_known : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown({load_i, update_i})
    ) else $error("coeff_bank: load_i or update_i unknown");

endmodule

`default_nettype wire

// File: dsp_arith/dsp_preadd.sv
`timescale 1ns/1ps
`default_nettype none

module dsp_preadd (
    input  wire                      clk_i,
    input  wire                      arst_n_i,
    input  wire dsp_pkg::ad_t        a_i,
    input  wire dsp_pkg::ad_t        d_i,
    input  wire dsp_pkg::pre_ctrl_t  pre_ctrl_i,
    output dsp_pkg::pre_t            pre_sum_o
);

    import dsp_pkg::*;

    ad_t  a_q;
    ad_t  d_q;
    pre_t a_ext;
    pre_t d_ext;
    pre_t sum;
    pre_t sum_q;

    // input registers, stage 1
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            a_q <= '0;
            d_q <= '0;
        end else begin
            a_q <= a_i;
            d_q <= d_i;
        end
    end

    // one guard bit so D-A never overflows
    assign a_ext = {a_q[$bits(ad_t)-1], a_q};
    assign d_ext = {d_q[$bits(ad_t)-1], d_q};

    always_comb begin
        if (pre_ctrl_i.sub_a) begin
            sum = d_ext - a_ext;
        end else begin
            sum = d_ext + a_ext;
        end
    end

    // pre-add register, stage 2
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sum_q <= '0;
        end else begin
            sum_q <= sum;
        end
    end

    assign pre_sum_o = sum_q;

endmodule

`default_nettype wire

// File: dsp_arith/dsp_mult_acc.sv
`timescale 1ns/1ps
`default_nettype none
`include "dsp_defines.svh"

module dsp_mult_acc (
    input  wire                       clk_i,
    input  wire                       arst_n_i,
    input  wire dsp_pkg::pre_t        pre_sum_i,
    input  wire dsp_pkg::coef_t       coef_i,
    input  wire dsp_pkg::acc_t        c_i,
    input  wire dsp_pkg::acc_t        pcin_i,
    input  wire dsp_pkg::post_ctrl_t  post_ctrl_i,
    output dsp_pkg::acc_t             p_o
);

    import dsp_pkg::*;

    localparam int PROD_W  = `DSP_PRE_W + `DSP_COEF_W;
    localparam int EXT_W   = `DSP_ACC_W - PROD_W;
    // C waits through input, pre-add and multiply stages
    localparam int C_DEPTH = `DSP_LATENCY - 1;

    logic signed [PROD_W-1:0] prod;
    acc_t m_q;
    acc_t c_line [C_DEPTH];
    acc_t c_term;
    acc_t pcin_term;
    logic carry_in;
    acc_t p_next;

    assign prod = pre_sum_i * coef_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_q <= '0;
            for (int i = 0; i < C_DEPTH; i++) begin
                c_line[i] <= '0;
            end
        end else begin
            m_q       <= {{EXT_W{prod[PROD_W-1]}}, prod};
            c_line[0] <= c_i;
            for (int i = 1; i < C_DEPTH; i++) begin
                c_line[i] <= c_line[i-1];
            end
        end
    end

    // subtraction is ~C plus a carry of one
    assign c_term    = !post_ctrl_i.use_c ? '0 :
                       post_ctrl_i.sub_c  ? ~c_line[C_DEPTH-1] : c_line[C_DEPTH-1];
    assign carry_in  = post_ctrl_i.use_c & post_ctrl_i.sub_c;
    // pcin arrives late, sampled straight into the P adder
    assign pcin_term = post_ctrl_i.add_pcin ? pcin_i : '0;

    assign p_next = m_q + c_term + pcin_term + {{(`DSP_ACC_W-1){1'b0}}, carry_in};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            p_o <= '0;
        end else begin
            p_o <= p_next;
        end
    end

    a_post_ctrl_known : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(post_ctrl_i)
    ) else $error("dsp_mult_acc: post_ctrl_i unknown");

endmodule

`default_nettype wire

// File: hw/fir_dsp_core.sv
`timescale 1ns/1ps
`default_nettype none

module fir_dsp_core (
    input  wire                    clk_i,
    input  wire                    arst_n_i,
    input  wire dsp_pkg::ad_t      a_i,
    input  wire dsp_pkg::ad_t      d_i,
    input  wire dsp_pkg::coef_t    b_i,
    input  wire dsp_pkg::acc_t     c_i,
    input  wire dsp_pkg::acc_t     pcin_i,
    input  wire dsp_pkg::dsp_op_t  op_i,
    input  wire                    load_i,
    input  wire                    update_i,
    output dsp_pkg::acc_t          p_o,
    output dsp_pkg::acc_t          pcout_o,
    output dsp_pkg::coef_t         bcout_o
);

    import dsp_pkg::*;

    pre_ctrl_t  pre_ctrl;
    post_ctrl_t post_ctrl;
    pre_t       pre_sum;
    coef_t      coef_active;

    // operation word pipeline, one stage ahead of each datapath register
    dsp_ctrl u_ctrl (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .op_i        (op_i),
        .pre_ctrl_o  (pre_ctrl),
        .post_ctrl_o (post_ctrl)
    );

    // double-buffered tap
    coeff_bank u_coeff (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .b_i           (b_i),
        .load_i        (load_i),
        .update_i      (update_i),
        .coef_active_o (coef_active),
        .bcout_o       (bcout_o)
    );

    dsp_preadd u_preadd (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .a_i        (a_i),
        .d_i        (d_i),
        .pre_ctrl_i (pre_ctrl),
        .pre_sum_o  (pre_sum)
    );

    dsp_mult_acc u_mult_acc (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .pre_sum_i   (pre_sum),
        .coef_i      (coef_active),
        .c_i         (c_i),
        .pcin_i      (pcin_i),
        .post_ctrl_i (post_ctrl),
        .p_o         (p_o)
    );

    // the cascade output is the P register itself
    assign pcout_o = p_o;

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, well away from the sampling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/tb_fir_dsp_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "dsp_defines.svh"

module tb_fir_dsp_core;

    import dsp_pkg::*;

    localparam int CLK_PERIOD_NS = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int SEED          = 16998;
    localparam int LAT           = `DSP_LATENCY;
    localparam int STREAM_LEN    = 20;
    localparam int HOLD_LEN      = 6;
    // fixed A and D in the coefficient test make every product 7 x tap
    localparam int FIXED_A       = 3;
    localparam int FIXED_D       = 4;
    localparam int TEST_CYCLES   = (2 + 2 * STREAM_LEN + LAT) + 2 * (2 * STREAM_LEN + LAT)
                                   + (6 + 4 * HOLD_LEN + LAT);
    localparam int MARGIN_CYCLES = 40;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

    // one driven sample plus the coefficient state after its edge
    typedef struct packed {
        ad_t     a;
        ad_t     d;
        acc_t    c;
        acc_t    pcin;
        dsp_op_t op;
        coef_t   coef;
    } sample_t;

    logic    clk;
    logic    arst_n;
    ad_t     a;
    ad_t     d;
    coef_t   b;
    acc_t    c;
    acc_t    pcin;
    dsp_op_t op;
    logic    load;
    logic    update;
    acc_t    p;
    acc_t    pcout;
    coef_t   bcout;

    // values the next step_cycle puts on the DUT inputs
    ad_t     drv_a;
    ad_t     drv_d;
    coef_t   drv_b;
    acc_t    drv_c;
    acc_t    drv_pcin;
    dsp_op_t drv_op;
    logic    drv_load;
    logic    drv_update;

    coef_t   shadow_model;
    coef_t   active_model;
    sample_t history[$];
    int      step_count;
    int      checks;
    int      errors;

    tb_clk_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    fir_dsp_core dut (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .a_i      (a),
        .d_i      (d),
        .b_i      (b),
        .c_i      (c),
        .pcin_i   (pcin),
        .op_i     (op),
        .load_i   (load),
        .update_i (update),
        .p_o      (p),
        .pcout_o  (pcout),
        .bcout_o  (bcout)
    );

    function automatic ad_t rand_ad();
        logic [31:0] r;
        r = $urandom();
        return r[`DSP_AD_W-1:0];
    endfunction

    function automatic coef_t rand_coef();
        logic [31:0] r;
        r = $urandom();
        return r[`DSP_COEF_W-1:0];
    endfunction

    function automatic acc_t rand_acc();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[`DSP_ACC_W-1:0];
    endfunction

    // P for sample k uses the tap active before edge k+2 and pcin seen at edge k+3
    function automatic acc_t expected_p(int k);
        sample_t s;
        longint  pre_v;
        longint  prod_v;
        longint  c_v;
        longint  pcin_v;
        longint  total;
        s = history[k];
        if (s.op.sub_a) begin
            pre_v = longint'($signed(s.d)) - longint'($signed(s.a));
        end else begin
            pre_v = longint'($signed(s.d)) + longint'($signed(s.a));
        end
        prod_v = pre_v * longint'($signed(history[k+1].coef));
        c_v = 0;
        if (s.op.use_c) begin
            c_v = s.op.sub_c ? -longint'($signed(s.c)) : longint'($signed(s.c));
        end
        pcin_v = s.op.add_pcin ? longint'($signed(history[k+3].pcin)) : 0;
        total = prod_v + c_v + pcin_v;
        return total[`DSP_ACC_W-1:0];
    endfunction

    function automatic acc_t fixed_product(coef_t tap);
        longint v;
        v = longint'(FIXED_A + FIXED_D) * longint'(tap);
        return v[`DSP_ACC_W-1:0];
    endfunction

    task automatic compare_acc(string name, acc_t exp_v, acc_t act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic compare_coef(string name, coef_t exp_v, coef_t act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic idle_drive();
        drv_a      = '0;
        drv_d      = '0;
        drv_b      = '0;
        drv_c      = '0;
        drv_pcin   = '0;
        drv_op     = '0;
        drv_load   = 1'b0;
        drv_update = 1'b0;
    endtask

    // one clock checks what the last edge produced and then drives the next sample
    task automatic step_cycle();
        sample_t rec;
        @(posedge clk);
        #1;
        if (step_count >= LAT) begin
            compare_acc("p_o", expected_p(step_count - LAT), p);
            compare_acc("pcout_o", expected_p(step_count - LAT), pcout);
        end
        compare_coef("bcout_o", shadow_model, bcout);
        a      = drv_a;
        d      = drv_d;
        b      = drv_b;
        c      = drv_c;
        pcin   = drv_pcin;
        op     = drv_op;
        load   = drv_load;
        update = drv_update;
        // update takes the shadow from before this edge
        if (drv_update) begin
            active_model = shadow_model;
        end
        if (drv_load) begin
            shadow_model = drv_b;
        end
        rec = '{a: drv_a, d: drv_d, c: drv_c, pcin: drv_pcin, op: drv_op, coef: active_model};
        history.push_back(rec);
        step_count++;
    endtask

    task automatic drain_pipeline();
        idle_drive();
        repeat (LAT) step_cycle();
    endtask

    task automatic reset_state();
        compare_acc("p_o", '0, p);
        compare_acc("pcout_o", '0, pcout);
        compare_coef("bcout_o", '0, bcout);
    endtask

    task automatic preadd_and_mult();
        idle_drive();
        drv_b    = rand_coef();
        drv_load = 1'b1;
        step_cycle();
        drv_load   = 1'b0;
        drv_update = 1'b1;
        step_cycle();
        drv_update = 1'b0;
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < STREAM_LEN; i++) begin
                drv_a        = rand_ad();
                drv_d        = rand_ad();
                drv_op       = '0;
                drv_op.sub_a = (pass == 1);
                step_cycle();
            end
        end
        drain_pipeline();
    endtask

    task automatic c_operand();
        logic [31:0] r;
        idle_drive();
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < STREAM_LEN; i++) begin
                r            = $urandom();
                drv_a        = rand_ad();
                drv_d        = rand_ad();
                drv_c        = rand_acc();
                drv_op       = '0;
                drv_op.sub_a = r[0];
                drv_op.use_c = 1'b1;
                drv_op.sub_c = (pass == 1);
                step_cycle();
            end
        end
        drain_pipeline();
    endtask

    task automatic cascade_input();
        logic [31:0] r;
        idle_drive();
        drv_pcin = rand_acc();
        // first pass holds pcin and the second pass changes it every cycle
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < STREAM_LEN; i++) begin
                r               = $urandom();
                drv_a           = rand_ad();
                drv_d           = rand_ad();
                drv_c           = rand_acc();
                drv_op          = '0;
                drv_op.add_pcin = 1'b1;
                drv_op.use_c    = (pass == 1) && r[0];
                drv_op.sub_c    = (pass == 1) && r[0] && r[1];
                if (pass == 1) begin
                    drv_pcin = rand_acc();
                end
                step_cycle();
            end
        end
        drain_pipeline();
    endtask

    task automatic coeff_double_buffer();
        coef_t first_tap;
        coef_t second_tap;
        coef_t third_tap;
        coef_t fourth_tap;
        first_tap  = coef_t'(1234);
        second_tap = coef_t'(-567);
        third_tap  = coef_t'(890);
        fourth_tap = coef_t'(-42);
        idle_drive();
        drv_a    = ad_t'(FIXED_A);
        drv_d    = ad_t'(FIXED_D);
        drv_b    = first_tap;
        drv_load = 1'b1;
        step_cycle();
        drv_load   = 1'b0;
        drv_update = 1'b1;
        step_cycle();
        drv_update = 1'b0;
        repeat (HOLD_LEN) step_cycle();
        compare_acc("p_o", fixed_product(first_tap), p);
        // load alone moves the shadow only
        drv_b    = second_tap;
        drv_load = 1'b1;
        step_cycle();
        drv_load = 1'b0;
        repeat (HOLD_LEN) step_cycle();
        compare_coef("bcout_o", second_tap, bcout);
        compare_acc("p_o", fixed_product(first_tap), p);
        drv_update = 1'b1;
        step_cycle();
        drv_update = 1'b0;
        repeat (HOLD_LEN) step_cycle();
        compare_acc("p_o", fixed_product(second_tap), p);
        // both strobes at once activate the older shadow
        drv_b    = third_tap;
        drv_load = 1'b1;
        step_cycle();
        drv_b      = fourth_tap;
        drv_update = 1'b1;
        step_cycle();
        drv_load   = 1'b0;
        drv_update = 1'b0;
        repeat (HOLD_LEN) step_cycle();
        compare_acc("p_o", fixed_product(third_tap), p);
        compare_coef("bcout_o", fourth_tap, bcout);
        drain_pipeline();
    endtask

    initial begin
        void'($urandom(SEED));
        a            = '0;
        d            = '0;
        b            = '0;
        c            = '0;
        pcin         = '0;
        op           = '0;
        load         = 1'b0;
        update       = 1'b0;
        shadow_model = '0;
        active_model = '0;
        step_count   = 0;
        checks       = 0;
        errors       = 0;
        idle_drive();
        wait (arst_n === 1'b1);
        reset_state();
        preadd_and_mult();
        c_operand();
        cascade_input();
        coeff_double_buffer();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/dsp_pkg.sv
hw/dsp_ctrl.sv
hw/coeff_bank.sv
dsp_arith/dsp_preadd.sv
dsp_arith/dsp_mult_acc.sv
hw/fir_dsp_core.sv
verification/tb_clk_gen.sv
verification/tb_fir_dsp_core.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_fir_dsp_core
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx 'TESTBENCH PASSED' $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
